//--- design/fp_convert_core.sv
// ##########################################################
// Warp-wide signed integer to float and float to signed
// integer conversions, both truncating
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module fp_convert_core (
    input  warp_fpu_pkg::warp_data_t a_i,
    output warp_fpu_pkg::warp_data_t to_fp_o,
    output warp_fpu_pkg::warp_data_t to_int_o
);
    import warp_fpu_pkg::*;

    // ##########################################################
    // Integer to float
    // ##########################################################

    function automatic lane_word_t int_to_fp(input lane_word_t v);
        logic [31:0] mag;
        logic [31:0] norm;
        int          msb;

        if (v == '0) begin
            return '0;
        end

        // Most negative value keeps magnitude 2^31
        mag = v[31] ? (~v + 32'd1) : v;

        // Position of the leading one
        msb = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end

        // Leading one to bit 31, low bits dropped
        norm = mag << (31 - msb);
        return {v[31], 8'(127 + msb), norm[30:8]};
    endfunction

    // ##########################################################
    // Float to integer
    // ##########################################################

    function automatic lane_word_t fp_to_int(input lane_word_t f);
        logic [7:0]  ex;
        logic [31:0] mag;

        ex = f[30:23];

        // Magnitude below one
        if (ex < 8'd127) begin
            return '0;
        end

        // 2^31 and above saturate by sign
        if (ex >= 8'd158) begin
            return f[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end

        // Shift relative to the binary point at bit 23
        mag = {8'd0, 1'b1, f[22:0]};
        if (ex >= 8'd150) begin
            mag = mag << (ex - 8'd150);
        end else begin
            mag = mag >> (8'd150 - ex);
        end

        return f[31] ? (~mag + 32'd1) : mag;
    endfunction

    always_comb begin
        for (int l = 0; l < WarpWidth; l++) begin
            to_fp_o[l]  = int_to_fp(a_i[l]);
            to_int_o[l] = fp_to_int(a_i[l]);
        end
    end

endmodule

`default_nettype wire

//--- design/fp_mul_core.sv
// ##########################################################
// Warp-wide single precision multiply, truncating,
// zero and denormal inputs flushed to zero
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module fp_mul_core (
    input  warp_fpu_pkg::warp_data_t a_i,
    input  warp_fpu_pkg::warp_data_t b_i,
    output warp_fpu_pkg::warp_data_t prod_o
);
    import warp_fpu_pkg::*;

    // ##########################################################
    // One lane
    // ##########################################################

    function automatic lane_word_t mul_lane(input lane_word_t a, input lane_word_t b);
        logic        sign;
        logic [47:0] mant_prod;
        logic [22:0] mant;
        int          exp;

        sign = a[31] ^ b[31];

        // Exponent zero flushes to signed zero
        if ((a[30:23] == 8'd0) || (b[30:23] == 8'd0)) begin
            return {sign, 31'd0};
        end

        // Hidden bits restored, 24x24 product
        mant_prod = {1'b1, a[22:0]} * {1'b1, b[22:0]};

        // Biased sum, bias removed once
        exp = int'(a[30:23]) + int'(b[30:23]) - 127;

        // Product in [1,4), at most one shift
        if (mant_prod[47]) begin
            mant = mant_prod[46:24];
            exp  = exp + 1;
        end else begin
            mant = mant_prod[45:23];
        end

        // Underflow to zero
        if (exp <= 0) begin
            return {sign, 31'd0};
        end

        // Overflow to infinity
        if (exp >= 255) begin
            return {sign, 8'hff, 23'd0};
        end

        return {sign, exp[7:0], mant};
    endfunction

    // ##########################################################
    // Lane array
    // ##########################################################

    always_comb begin
        for (int l = 0; l < WarpWidth; l++) begin
            prod_o[l] = mul_lane(a_i[l], b_i[l]);
        end
    end

endmodule

`default_nettype wire

//--- design/fpu_issue.sv
// ##########################################################
// Issue stage: station pick, input handshake, decode and
// warp-wide result selection
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module fpu_issue #(
    parameter int unsigned NumStations = 5
) (
    // Operand collector side
    input  logic                       in_valid_i,
    input  warp_fpu_pkg::issue_req_t   in_req_i,
    output logic                       in_ready_o,

    // Station occupancy
    input  logic [NumStations-1:0]     station_free_i,

    // Station allocation
    output logic                       alloc_valid_o,
    output warp_fpu_pkg::station_idx_t alloc_station_o,
    output warp_fpu_pkg::fpu_result_t  alloc_meta_o,

    // Per-operation strobes into the latency pipes
    output logic                       mul_valid_o,
    output logic                       i2f_valid_o,
    output logic                       f2i_valid_o,
    output warp_fpu_pkg::lane_result_t exec_o
);
    import warp_fpu_pkg::*;

    logic         accept;
    station_idx_t pick;
    warp_data_t   prod;
    warp_data_t   to_fp;
    warp_data_t   to_int;
    warp_data_t   sel;

    // ##########################################################
    // Execution cores
    // ##########################################################

    fp_mul_core u_mul (
        .a_i    (in_req_i.operand_a),
        .b_i    (in_req_i.operand_b),
        .prod_o (prod)
    );

    // Conversions only read operand A
    fp_convert_core u_cvt (
        .a_i      (in_req_i.operand_a),
        .to_fp_o  (to_fp),
        .to_int_o (to_int)
    );

    // ##########################################################
    // Station pick and handshake
    // ##########################################################

    // Lowest free station wins
    always_comb begin
        pick = '0;
        for (int i = NumStations - 1; i >= 0; i--) begin
            if (station_free_i[i]) begin
                pick = station_idx_t'(i);
            end
        end
    end

    // Ready only depends on occupancy
    assign in_ready_o = |station_free_i;
    assign accept     = in_valid_i && in_ready_o;

    assign alloc_valid_o   = accept;
    assign alloc_station_o = pick;
    assign alloc_meta_o    = '{tag: in_req_i.tag, dst: in_req_i.dst,
                               act_mask: in_req_i.act_mask, data: '0};

    // One strobe per accepted instruction
    assign mul_valid_o = accept && (in_req_i.op == FPU_MUL);
    assign i2f_valid_o = accept && (in_req_i.op == FPU_INT_TO_FP);
    assign f2i_valid_o = accept && (in_req_i.op == FPU_FP_TO_INT);

    // Result mux, inactive lanes forced to zero
    always_comb begin
        case (in_req_i.op)
            FPU_INT_TO_FP: sel = to_fp;
            FPU_FP_TO_INT: sel = to_int;
            default:       sel = prod;
        endcase
        exec_o.station = pick;
        for (int l = 0; l < WarpWidth; l++) begin
            exec_o.data[l] = in_req_i.act_mask[l] ? sel[l] : '0;
        end
    end

    // Only the three decoded codes may be issued
    always_comb begin
        if (in_valid_i) begin
            assert (in_req_i.op inside {FPU_MUL, FPU_INT_TO_FP, FPU_FP_TO_INT})
            else $error("Illegal FPU operation %0d", in_req_i.op);
        end
    end

endmodule

`default_nettype wire

//--- design/fpu_latency_pipe.sv
// ##########################################################
// Fixed latency delay line for a valid bit and its payload
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module fpu_latency_pipe #(
    parameter int unsigned Latency   = 1,
    parameter type         payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic [Latency-1:0] valid_q;
    payload_t           data_q [Latency];

    // Valid shift register, cleared on reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= valid_i;
            for (int i = 1; i < Latency; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload moves alongside every cycle
    always_ff @(posedge clk_i) begin
        data_q[0] <= data_i;
        for (int i = 1; i < Latency; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign valid_o = valid_q[Latency-1];
    assign data_o  = data_q[Latency-1];

endmodule

`default_nettype wire

//--- design/fpu_station_table.sv
// ##########################################################
// Completion stations: out of order write-back and
// round-robin hand-off to the result collector
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module fpu_station_table #(
    parameter int unsigned NumStations = 5
) (
    input  logic                       clk_i,
    input  logic                       rst_i,

    // Allocation from issue
    input  logic                       alloc_valid_i,
    input  warp_fpu_pkg::station_idx_t alloc_station_i,
    input  warp_fpu_pkg::fpu_result_t  alloc_meta_i,

    // Write-back from the latency pipes
    input  logic                       wr_mul_valid_i,
    input  warp_fpu_pkg::lane_result_t wr_mul_data_i,
    input  logic                       wr_i2f_valid_i,
    input  warp_fpu_pkg::lane_result_t wr_i2f_data_i,
    input  logic                       wr_f2i_valid_i,
    input  warp_fpu_pkg::lane_result_t wr_f2i_data_i,

    output logic [NumStations-1:0]     station_free_o,

    // Result collector side
    output logic                       res_valid_o,
    output warp_fpu_pkg::fpu_result_t  res_o,
    input  logic                       res_ready_i
);
    import warp_fpu_pkg::*;

    fpu_result_t            entry_q [NumStations];
    logic [NumStations-1:0] occ_q;
    logic [NumStations-1:0] done_q;
    logic [NumStations-1:0] ready_vec;
    station_idx_t           rr_q;
    station_idx_t           held_q;
    station_idx_t           pick;
    station_idx_t           grant;
    station_idx_t           rr_next;
    logic                   lock_q;
    logic                   found;
    logic                   xfer;

    // ##########################################################
    // Station storage
    // ##########################################################

    // Metadata at allocation, data at write-back
    always_ff @(posedge clk_i) begin
        if (alloc_valid_i) begin
            entry_q[alloc_station_i] <= alloc_meta_i;
        end
        if (wr_mul_valid_i) begin
            entry_q[wr_mul_data_i.station].data <= wr_mul_data_i.data;
        end
        if (wr_i2f_valid_i) begin
            entry_q[wr_i2f_data_i.station].data <= wr_i2f_data_i.data;
        end
        if (wr_f2i_valid_i) begin
            entry_q[wr_f2i_data_i.station].data <= wr_f2i_data_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            occ_q  <= '0;
            done_q <= '0;
            rr_q   <= '0;
            held_q <= '0;
            lock_q <= 1'b0;
        end else begin
            if (alloc_valid_i) begin
                occ_q[alloc_station_i]  <= 1'b1;
                done_q[alloc_station_i] <= 1'b0;
            end
            // Finished, offered from next cycle
            if (wr_mul_valid_i) begin
                done_q[wr_mul_data_i.station] <= 1'b1;
            end
            if (wr_i2f_valid_i) begin
                done_q[wr_i2f_data_i.station] <= 1'b1;
            end
            if (wr_f2i_valid_i) begin
                done_q[wr_f2i_data_i.station] <= 1'b1;
            end
            // Transfer frees the station, pointer moves past it
            if (xfer) begin
                occ_q[grant]  <= 1'b0;
                done_q[grant] <= 1'b0;
                rr_q          <= rr_next;
            end
            // Hold the choice while the collector stalls
            lock_q <= res_valid_o && !res_ready_i;
            held_q <= grant;
        end
    end

    assign station_free_o = ~occ_q;

    // ##########################################################
    // Round-robin output choice
    // ##########################################################

    assign ready_vec = occ_q & done_q;

    // First ready station at or after the pointer
    always_comb begin
        int unsigned cand;
        found = 1'b0;
        pick  = rr_q;
        for (int unsigned off = 0; off < NumStations; off++) begin
            cand = (int'(rr_q) + off) % NumStations;
            if (!found && ready_vec[cand]) begin
                found = 1'b1;
                pick  = station_idx_t'(cand);
            end
        end
    end

    assign grant       = lock_q ? held_q : pick;
    assign rr_next     = (grant == station_idx_t'(NumStations - 1)) ? '0 : grant + 1'b1;
    assign res_valid_o = lock_q || found;
    assign res_o       = entry_q[grant];
    assign xfer        = res_valid_o && res_ready_i;

    // ##########################################################
    // Assertions
    // ##########################################################

    assert property (@(posedge clk_i)
        (NumStations >= 2) && (NumStations <= 2 ** StationIdxWidth))
        else $error("NumStations %0d out of range", NumStations);

    // Writes land only in reserved stations
    assert property (@(posedge clk_i) disable iff (rst_i)
        (!wr_mul_valid_i || occ_q[wr_mul_data_i.station]) &&
        (!wr_i2f_valid_i || occ_q[wr_i2f_data_i.station]) &&
        (!wr_f2i_valid_i || occ_q[wr_f2i_data_i.station]))
        else $error("Write-back to unoccupied station");

    assert property (@(posedge clk_i) disable iff (rst_i)
        alloc_valid_i |-> !occ_q[alloc_station_i])
        else $error("Allocation of occupied station %0d", alloc_station_i);

    // Offered result holds until taken
    assert property (@(posedge clk_i) disable iff (rst_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
        else $error("Result changed under back-pressure");

endmodule

`default_nettype wire

//--- design/warp_fpu.sv
// ##########################################################
// Warp-wide FPU top: issue, latency pipes, stations
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module warp_fpu #(
    parameter int unsigned NumStations = 5,
    parameter int unsigned MulLatency  = 3,
    parameter int unsigned I2fLatency  = 2,
    parameter int unsigned F2iLatency  = 1
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  logic                      in_valid_i,
    input  warp_fpu_pkg::issue_req_t  in_req_i,
    output logic                      in_ready_o,

    output logic                      res_valid_o,
    output warp_fpu_pkg::fpu_result_t res_o,
    input  logic                      res_ready_i
);
    import warp_fpu_pkg::*;

    logic [NumStations-1:0] station_free;
    logic                   alloc_valid;
    station_idx_t           alloc_station;
    fpu_result_t            alloc_meta;
    logic                   mul_valid;
    logic                   i2f_valid;
    logic                   f2i_valid;
    lane_result_t           exec;

    // Pipe outputs
    logic                   mul_out_valid;
    logic                   i2f_out_valid;
    logic                   f2i_out_valid;
    lane_result_t           mul_out;
    lane_result_t           i2f_out;
    lane_result_t           f2i_out;

    fpu_issue #(
        .NumStations (NumStations)
    ) u_issue (
        .in_valid_i      (in_valid_i),
        .in_req_i        (in_req_i),
        .in_ready_o      (in_ready_o),
        .station_free_i  (station_free),
        .alloc_valid_o   (alloc_valid),
        .alloc_station_o (alloc_station),
        .alloc_meta_o    (alloc_meta),
        .mul_valid_o     (mul_valid),
        .i2f_valid_o     (i2f_valid),
        .f2i_valid_o     (f2i_valid),
        .exec_o          (exec)
    );

    // Same payload into all three pipes, strobes pick the owner
    fpu_latency_pipe #(.Latency(MulLatency), .payload_t(lane_result_t)) u_mul_pipe (
        .clk_i (clk_i), .rst_i (rst_i),
        .valid_i (mul_valid), .data_i (exec),
        .valid_o (mul_out_valid), .data_o (mul_out)
    );

    fpu_latency_pipe #(.Latency(I2fLatency), .payload_t(lane_result_t)) u_i2f_pipe (
        .clk_i (clk_i), .rst_i (rst_i),
        .valid_i (i2f_valid), .data_i (exec),
        .valid_o (i2f_out_valid), .data_o (i2f_out)
    );

    fpu_latency_pipe #(.Latency(F2iLatency), .payload_t(lane_result_t)) u_f2i_pipe (
        .clk_i (clk_i), .rst_i (rst_i),
        .valid_i (f2i_valid), .data_i (exec),
        .valid_o (f2i_out_valid), .data_o (f2i_out)
    );

    fpu_station_table #(
        .NumStations (NumStations)
    ) u_stations (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .alloc_valid_i   (alloc_valid),
        .alloc_station_i (alloc_station),
        .alloc_meta_i    (alloc_meta),
        .wr_mul_valid_i  (mul_out_valid),
        .wr_mul_data_i   (mul_out),
        .wr_i2f_valid_i  (i2f_out_valid),
        .wr_i2f_data_i   (i2f_out),
        .wr_f2i_valid_i  (f2i_out_valid),
        .wr_f2i_data_i   (f2i_out),
        .station_free_o  (station_free),
        .res_valid_o     (res_valid_o),
        .res_o           (res_o),
        .res_ready_i     (res_ready_i)
    );

endmodule

`default_nettype wire

//--- design/warp_fpu_pkg.sv
// ##########################################################
// Shared widths, operation codes and payload structs for
// the warp-wide floating point unit
// ##########################################################

`default_nettype none

package warp_fpu_pkg;

    // ##########################################################
    // Widths
    // ##########################################################

    // Threads per warp
    parameter int unsigned WarpWidth = 4;
    // Bits per lane word
    parameter int unsigned RegWidth = 32;
    parameter int unsigned TagWidth = 5;
    parameter int unsigned RegIdxWidth = 8;
    // Up to 8 completion stations
    parameter int unsigned StationIdxWidth = 3;

    // ##########################################################
    // Types
    // ##########################################################

    typedef logic [RegWidth-1:0] lane_word_t;
    typedef lane_word_t [WarpWidth-1:0] warp_data_t;
    typedef logic [WarpWidth-1:0] act_mask_t;
    typedef logic [StationIdxWidth-1:0] station_idx_t;

    // Code 2'b11 is illegal
    typedef enum logic [1:0] {
        FPU_MUL       = 2'd0,
        FPU_INT_TO_FP = 2'd1,
        FPU_FP_TO_INT = 2'd2
    } fpu_op_e;

    // Instruction from the operand collector
    typedef struct packed {
        logic [TagWidth-1:0]    tag;
        logic [RegIdxWidth-1:0] dst;
        act_mask_t              act_mask;
        fpu_op_e                op;
        warp_data_t             operand_a;
        warp_data_t             operand_b;
    } issue_req_t;

    // Latency pipe payload, result tagged with its station
    typedef struct packed {
        station_idx_t station;
        warp_data_t   data;
    } lane_result_t;

    // Result handed to the result collector
    typedef struct packed {
        logic [TagWidth-1:0]    tag;
        logic [RegIdxWidth-1:0] dst;
        act_mask_t              act_mask;
        warp_data_t             data;
    } fpu_result_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the warp FPU testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_warp_fpu -f warp_fpu.f -o sim_warp_fpu \
    && ./obj_dir/sim_warp_fpu > sim.log 2>&1 \
    || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

//--- testbench/tb_warp_fpu.sv
// ##########################################################
// Testbench for the warp FPU: random instructions, model,
// scoreboard by tag and a watchdog
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tb_warp_fpu;
    import warp_fpu_pkg::*;

    localparam int NumStations = 5;
    localparam int MulLatency  = 3;
    localparam int I2fLatency  = 2;
    localparam int F2iLatency  = 1;
    localparam int NumInstr    = 400;
    // 40 cycles of 20 ns per instruction
    localparam int WatchdogNs  = NumInstr * 40 * 20;
    // Every station emptied well within this many cycles
    localparam int DrainCycles = 100;

    logic        clk_i;
    logic        rst_i;
    logic        in_valid_i;
    issue_req_t  in_req_i;
    logic        in_ready_o;
    logic        res_valid_o;
    fpu_result_t res_o;
    logic        res_ready_i;

    // Stimulus and scoreboard state
    logic [31:0]         lfsr_q;
    logic [TagWidth-1:0] tag_ctr;
    fpu_result_t         exp_tab [32];
    logic [31:0]         live;
    int                  outstanding;
    int                  issued;
    int                  completed;
    int                  cycle;
    int                  drained;
    logic                hold_req;
    logic                stalled;
    fpu_result_t         stalled_res;

    warp_fpu #(
        .NumStations (NumStations),
        .MulLatency  (MulLatency),
        .I2fLatency  (I2fLatency),
        .F2iLatency  (F2iLatency)
    ) dut0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_req_i    (in_req_i),
        .in_ready_o  (in_ready_o),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .res_ready_i (res_ready_i)
    );

    always #10 clk_i = ~clk_i;

    // ##########################################################
    // Random source and failure handling
    // ##########################################################

    // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_result(input fpu_result_t got, input fpu_result_t exp,
                                input string what);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_logic(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    // ##########################################################
    // Reference model
    // ##########################################################

    // Truncating multiply, exponent zero flushes
    function automatic lane_word_t ref_mul(input lane_word_t a, input lane_word_t b);
        logic        s;
        longint      m;
        int          e;
        logic [22:0] f;
        s = a[31] ^ b[31];
        if (a[30:23] == 8'd0 || b[30:23] == 8'd0) begin
            return {s, 31'd0};
        end
        m = longint'({1'b1, a[22:0]}) * longint'({1'b1, b[22:0]});
        e = int'(a[30:23]) + int'(b[30:23]) - 127;
        if (m >= (64'sd1 <<< 47)) begin
            e = e + 1;
            f = 23'(m >> 24);
        end else begin
            f = 23'(m >> 23);
        end
        if (e <= 0) begin
            return {s, 31'd0};
        end
        if (e >= 255) begin
            return {s, 8'hff, 23'd0};
        end
        return {s, 8'(e), f};
    endfunction

    // Leading one found by shifting up, low bits dropped
    function automatic lane_word_t ref_i2f(input lane_word_t v);
        logic [31:0] mag;
        int          e;
        if (v == '0) begin
            return '0;
        end
        mag = v[31] ? -v : v;
        e   = 158;
        while (!mag[31]) begin
            mag = mag << 1;
            e   = e - 1;
        end
        return {v[31], 8'(e), mag[30:8]};
    endfunction

    // Toward zero, saturating from 2^31 up
    function automatic lane_word_t ref_f2i(input lane_word_t f);
        int     e;
        longint mag;
        e = int'(f[30:23]) - 127;
        if (e < 0) begin
            return '0;
        end
        if (e >= 31) begin
            return f[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end
        mag = longint'({1'b1, f[22:0]});
        mag = (e >= 23) ? (mag << (e - 23)) : (mag >> (23 - e));
        if (f[31]) begin
            mag = -mag;
        end
        return 32'(mag);
    endfunction

    function automatic fpu_result_t expect_result(input issue_req_t r);
        fpu_result_t x;
        x.tag      = r.tag;
        x.dst      = r.dst;
        x.act_mask = r.act_mask;
        x.data     = '0;
        // Inactive lanes stay zero
        for (int l = 0; l < WarpWidth; l++) begin
            if (r.act_mask[l]) begin
                case (r.op)
                    FPU_INT_TO_FP: x.data[l] = ref_i2f(r.operand_a[l]);
                    FPU_FP_TO_INT: x.data[l] = ref_f2i(r.operand_a[l]);
                    default:       x.data[l] = ref_mul(r.operand_a[l], r.operand_b[l]);
                endcase
            end
        end
        return x;
    endfunction

    // ##########################################################
    // Stimulus
    // ##########################################################

    // Edge values: zeros, denormals, saturation limits, below one
    function automatic lane_word_t directed_word(input logic [3:0] k);
        case (k)
            4'd0:    return 32'h0000_0000;
            4'd1:    return 32'h8000_0000;
            4'd2:    return 32'h7fff_ffff;
            4'd3:    return 32'h0000_0001;
            4'd4:    return 32'hffff_ffff;
            4'd5:    return 32'h3f80_0000;
            4'd6:    return 32'h3f7f_ffff;
            4'd7:    return 32'hbf7f_ffff;
            4'd8:    return 32'h4f00_0000;
            4'd9:    return 32'hcf00_0000;
            4'd10:   return 32'h4eff_ffff;
            4'd11:   return 32'hceff_ffff;
            4'd12:   return 32'h7f80_0000;
            4'd13:   return 32'h0040_0000;
            4'd14:   return 32'h4b00_0001;
            default: return 32'hc049_0fdb;
        endcase
    endfunction

    function automatic lane_word_t make_operand(input fpu_op_e op);
        logic [31:0] w;
        logic [7:0]  ex;
        if (rand_bits(3) == 0) begin
            return directed_word(4'(rand_bits(4)));
        end
        if (op == FPU_INT_TO_FP) begin
            w = rand_bits(32);
            return $signed(w) >>> rand_bits(5);
        end
        // F2I exponents span below one to saturation
        if (op == FPU_FP_TO_INT) begin
            ex = 8'd112 + 8'(rand_bits(6));
        end else begin
            ex = 8'd64 + 8'(rand_bits(7));
        end
        return {1'(rand_bits(1)), ex, 23'(rand_bits(23))};
    endfunction

    function automatic issue_req_t make_request();
        issue_req_t r;
        logic [1:0] op_bits;
        r.tag      = tag_ctr;
        r.dst      = 8'(rand_bits(8));
        r.act_mask = 4'(rand_bits(4));
        op_bits    = 2'(rand_bits(2));
        case (op_bits)
            2'd1:    r.op = FPU_INT_TO_FP;
            2'd2:    r.op = FPU_FP_TO_INT;
            default: r.op = FPU_MUL;
        endcase
        for (int l = 0; l < WarpWidth; l++) begin
            r.operand_a[l] = make_operand(r.op);
            r.operand_b[l] = make_operand(FPU_MUL);
        end
        return r;
    endfunction

    // ##########################################################
    // Per-cycle scoreboard, inputs already settled
    // ##########################################################

    task automatic observe_cycle();
        logic accepted;
        logic taken;
        check_logic(in_ready_o, outstanding < NumStations, "in_ready_o");
        // Offered result must hold under back-pressure
        if (stalled) begin
            check_logic(res_valid_o, 1'b1, "res_valid_o while stalled");
            check_result(res_o, stalled_res, "res_o while stalled");
        end
        accepted = in_valid_i && in_ready_o;
        taken    = res_valid_o && res_ready_i;
        // Completion before issue so a new tag cannot mask an old one
        if (taken) begin
            if (!live[res_o.tag]) begin
                report_failure($sformatf("Result with tag %0d that is not in flight",
                                         res_o.tag));
            end
            check_result(res_o, exp_tab[res_o.tag], "result");
            live[res_o.tag] = 1'b0;
            completed++;
        end
        if (accepted) begin
            exp_tab[in_req_i.tag] = expect_result(in_req_i);
            live[in_req_i.tag]    = 1'b1;
            tag_ctr               = tag_ctr + 1'b1;
            issued++;
        end
        outstanding = outstanding + int'(accepted) - int'(taken);
        hold_req    = in_valid_i && !accepted;
        stalled     = res_valid_o && !res_ready_i;
        stalled_res = res_o;
    endtask

    // ##########################################################
    // Main sequence
    // ##########################################################

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        in_valid_i  = 1'b0;
        in_req_i    = '0;
        res_ready_i = 1'b0;
        lfsr_q      = 32'd54;
        tag_ctr     = '0;
        live        = '0;
        outstanding = 0;
        issued      = 0;
        completed   = 0;
        cycle       = 0;
        drained     = 0;
        hold_req    = 1'b0;
        stalled     = 1'b0;
        stalled_res = '0;

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        #1;
        check_logic(res_valid_o, 1'b0, "res_valid_o after reset");
        check_logic(in_ready_o, 1'b1, "in_ready_o after reset");

        while (issued < NumInstr) begin
            @(negedge clk_i);
            // Unaccepted request stays as it is
            if (!hold_req) begin
                if (rand_bits(2) != 0) begin
                    in_req_i   = make_request();
                    in_valid_i = 1'b1;
                end else begin
                    in_valid_i = 1'b0;
                end
            end
            // Stall window fills the stations, random stalls elsewhere
            res_ready_i = ((cycle % 64) >= 20) && (rand_bits(2) != 0);
            cycle++;
            #1;
            observe_cycle();
        end

        // Drain with the collector always ready, for a bounded time
        while (outstanding != 0 && drained < DrainCycles) begin
            @(negedge clk_i);
            in_valid_i  = 1'b0;
            res_ready_i = 1'b1;
            #1;
            observe_cycle();
            drained++;
        end

        if (live == '0 && completed == issued) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_failure($sformatf("%0d of %0d instructions never completed",
                                     issued - completed, issued));
        end
    end

    // Watchdog
    initial begin
        #(WatchdogNs);
        report_failure($sformatf("Timeout: run did not finish within %0d ns", WatchdogNs));
    end

endmodule

`default_nettype wire

//--- warp_fpu.f
design/warp_fpu_pkg.sv
design/fp_mul_core.sv
design/fp_convert_core.sv
design/fpu_issue.sv
design/fpu_latency_pipe.sv
design/fpu_station_table.sv
design/warp_fpu.sv
testbench/tb_warp_fpu.sv
